//--- uart_hub_defines.svh
// Build-time sizing for the UART transmit hub
// Queue depth also sets the credits each producer owns after reset
// Port index type in the package is one bit, so port count stays at 2
`ifndef UART_HUB_DEFINES_SVH
`define UART_HUB_DEFINES_SVH

////////////////////////////////////////
// Queue and port sizing
////////////////////////////////////////

// Entries per producer queue, equal to initial credits
`define UART_HUB_FIFO_DEPTH 4

// Number of byte producers sharing the transmitter
`define UART_HUB_NUM_PORTS 2

// Width of clocks-per-bit input and bit-period counter
`define UART_HUB_CPB_WIDTH 16

`endif

//--- uart_hub_pkg.sv
// Shared types for the UART transmit hub
// port_idx_t is sized for two producers only
package uart_hub_pkg;

  ////////////////////////////////////////
  // Payload types
  ////////////////////////////////////////

  // One serial data byte
  typedef logic [7:0] data_t;

  // Producer number, one bit covers two ports
  typedef logic [0:0] port_idx_t;

  // Request word from arbiter to transmitter
  // Source tag travels with the byte for the whole frame
  typedef struct packed {
    port_idx_t src;
    data_t     data;
  } tx_req_t;

endpackage

//--- credit_fifo.sv
// Per-producer byte queue with credit-based flow control
// Producer starts with UART_HUB_FIFO_DEPTH credits and writes only against one
// Writes while full are a producer error and do not touch stored entries
// One credit returns per pop, registered one cycle after the pop
`include "uart_hub_defines.svh"

module credit_fifo
  import uart_hub_pkg::*;
(
  input  logic  i_Clock,
  input  logic  i_Rst_L,
  input  logic  i_wr_valid,
  input  data_t i_wr_data,
  input  logic  i_pop,
  output logic  o_not_empty,
  output data_t o_head,
  output logic  o_credit_return
);

  localparam int DEPTH = `UART_HUB_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  data_t            r_mem [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             w_push;
  logic             w_pop;

  // Qualified push and pop
  assign w_push = i_wr_valid && (r_count != CNT_W'(DEPTH));
  assign w_pop  = i_pop && o_not_empty;

  assign o_not_empty = (r_count != '0);
  assign o_head      = r_mem[r_rd_ptr];

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge i_Clock)
  begin
    if (w_push)
    begin
      r_mem[r_wr_ptr] <= i_wr_data;
    end
  end

  ////////////////////////////////////////
  // Pointers, occupancy, credit return
  ////////////////////////////////////////

  always_ff @(posedge i_Clock or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_wr_ptr        <= '0;
      r_rd_ptr        <= '0;
      r_count         <= '0;
      o_credit_return <= 1'b0;
    end
    else
    begin
      // Circular wrap, depth need not be a power of two
      if (w_push)
      begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (w_pop)
      begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      end
      // Push and pop together leave the count unchanged
      if (w_push && !w_pop)
      begin
        r_count <= r_count + 1'b1;
      end
      else if (w_pop && !w_push)
      begin
        r_count <= r_count - 1'b1;
      end
      // One credit back per entry removed
      o_credit_return <= w_pop;
    end
  end

endmodule

//--- tx_arbiter.sv
// Round-robin arbiter between producer queues and the transmitter
// Grants only while the transmitter is idle and no request went out last cycle
// Pop is combinational; request word and valid are registered
`include "uart_hub_defines.svh"

module tx_arbiter
  import uart_hub_pkg::*;
(
  input  logic                              i_Clock,
  input  logic                              i_Rst_L,
  input  logic  [`UART_HUB_NUM_PORTS-1:0]   i_not_empty,
  input  data_t [`UART_HUB_NUM_PORTS-1:0]   i_head,
  input  logic                              i_tx_busy,
  output logic  [`UART_HUB_NUM_PORTS-1:0]   o_pop,
  output logic                              o_req_valid,
  output tx_req_t                           o_req
);

  localparam int NUM_PORTS = `UART_HUB_NUM_PORTS;

  port_idx_t r_last;
  port_idx_t w_grant_idx;
  logic      w_grant_any;

  ////////////////////////////////////////
  // Grant selection
  ////////////////////////////////////////

  // Search starts one past the last winner
  always_comb
  begin
    int idx;
    idx         = 0;
    w_grant_any = 1'b0;
    w_grant_idx = '0;
    o_pop       = '0;
    // Busy is not yet visible in the cycle after an issue
    if (!i_tx_busy && !o_req_valid)
    begin
      for (int k = 1; k <= NUM_PORTS; k++)
      begin
        idx = (int'(r_last) + k) % NUM_PORTS;
        if (i_not_empty[idx] && !w_grant_any)
        begin
          w_grant_any = 1'b1;
          w_grant_idx = port_idx_t'(idx);
        end
      end
    end
    if (w_grant_any)
    begin
      o_pop[w_grant_idx] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Registered request
  ////////////////////////////////////////

  always_ff @(posedge i_Clock or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      // Port 0 wins the first contest
      r_last      <= port_idx_t'(NUM_PORTS - 1);
      o_req_valid <= 1'b0;
    end
    else
    begin
      o_req_valid <= w_grant_any;
      // Pointer moves only on a grant
      if (w_grant_any)
      begin
        r_last <= w_grant_idx;
      end
    end
  end

  // Tagged byte, qualified by o_req_valid
  always_ff @(posedge i_Clock)
  begin
    if (w_grant_any)
    begin
      o_req.src  <= w_grant_idx;
      o_req.data <= i_head[w_grant_idx];
    end
  end

endmodule

//--- uart_tx.sv
// 8N1 serial transmitter, LSB first, no parity
// i_clks_per_bit = clock rate / baud rate, must be at least 1
// Period is sampled every cycle, so hold it steady during a frame
// Start bit drives the line one cycle after i_req_valid
// Done pulses the cycle after the last stop-bit cycle as busy falls
`include "uart_hub_defines.svh"

module uart_tx
  import uart_hub_pkg::*;
(
  input  logic                           i_Clock,
  input  logic                           i_Rst_L,
  input  logic                           i_req_valid,
  input  tx_req_t                        i_req,
  input  logic [`UART_HUB_CPB_WIDTH-1:0] i_clks_per_bit,
  output logic                           o_tx_busy,
  output logic                           o_tx_serial,
  output port_idx_t                      o_tx_src,
  output logic                           o_tx_done
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } tx_state_t;

  tx_state_t                      r_state;
  logic [`UART_HUB_CPB_WIDTH-1:0] r_clk_cnt;
  logic [2:0]                     r_bit_idx;
  data_t                          r_data;
  logic                           w_bit_end;
  logic                           w_accept;

  // Last clock of the current bit period
  assign w_bit_end = (r_clk_cnt == i_clks_per_bit - 1'b1);
  assign w_accept  = (r_state == S_IDLE) && i_req_valid;

  // Frame byte held until the stop bit
  always_ff @(posedge i_Clock)
  begin
    if (w_accept)
    begin
      r_data <= i_req.data;
    end
  end

  ////////////////////////////////////////
  // Frame state machine
  ////////////////////////////////////////

  always_ff @(posedge i_Clock or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state     <= S_IDLE;
      r_clk_cnt   <= '0;
      r_bit_idx   <= '0;
      o_tx_busy   <= 1'b0;
      o_tx_serial <= 1'b1;
      o_tx_src    <= '0;
      o_tx_done   <= 1'b0;
    end
    else
    begin
      o_tx_done <= 1'b0;
      case (r_state)
        S_IDLE:
        begin
          r_clk_cnt <= '0;
          r_bit_idx <= '0;
          if (i_req_valid)
          begin
            // Start bit goes out with busy
            o_tx_serial <= 1'b0;
            o_tx_busy   <= 1'b1;
            o_tx_src    <= i_req.src;
            r_state     <= S_START;
          end
          else
          begin
            o_tx_serial <= 1'b1;
          end
        end

        S_START:
        begin
          if (w_bit_end)
          begin
            r_clk_cnt   <= '0;
            o_tx_serial <= r_data[0];
            r_state     <= S_DATA;
          end
          else
          begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end

        S_DATA:
        begin
          if (w_bit_end)
          begin
            r_clk_cnt <= '0;
            if (r_bit_idx == 3'd7)
            begin
              // Stop bit
              o_tx_serial <= 1'b1;
              r_state     <= S_STOP;
            end
            else
            begin
              o_tx_serial <= r_data[r_bit_idx + 3'd1];
              r_bit_idx   <= r_bit_idx + 3'd1;
            end
          end
          else
          begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end

        S_STOP:
        begin
          if (w_bit_end)
          begin
            r_clk_cnt <= '0;
            o_tx_busy <= 1'b0;
            o_tx_done <= 1'b1;
            r_state   <= S_IDLE;
          end
          else
          begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end

        default:
        begin
          r_state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

//--- uart_tx_hub.sv
// Two credit-based byte queues sharing one 8N1 transmitter
// Each producer owns UART_HUB_FIFO_DEPTH credits after reset
// Idle hub latency is 3 cycles from write to start bit
// o_tx_src names the producer of the frame on the line
`include "uart_hub_defines.svh"

module uart_tx_hub
  import uart_hub_pkg::*;
(
  input  logic                              i_Clock,
  input  logic                              i_Rst_L,
  input  logic  [`UART_HUB_CPB_WIDTH-1:0]   i_clks_per_bit,
  input  logic  [`UART_HUB_NUM_PORTS-1:0]   i_wr_valid,
  input  data_t [`UART_HUB_NUM_PORTS-1:0]   i_wr_data,
  output logic  [`UART_HUB_NUM_PORTS-1:0]   o_credit_return,
  output logic                              o_tx_serial,
  output logic                              o_tx_active,
  output port_idx_t                         o_tx_src,
  output logic                              o_tx_done
);

  logic  [`UART_HUB_NUM_PORTS-1:0] w_not_empty;
  data_t [`UART_HUB_NUM_PORTS-1:0] w_head;
  logic  [`UART_HUB_NUM_PORTS-1:0] w_pop;
  logic                            w_req_valid;
  tx_req_t                         w_req;

  ////////////////////////////////////////
  // Producer queues
  ////////////////////////////////////////

  for (genvar p = 0; p < `UART_HUB_NUM_PORTS; p++)
  begin : g_port
    credit_fifo u_fifo (
      .i_Clock         (i_Clock),
      .i_Rst_L         (i_Rst_L),
      .i_wr_valid      (i_wr_valid[p]),
      .i_wr_data       (i_wr_data[p]),
      .i_pop           (w_pop[p]),
      .o_not_empty     (w_not_empty[p]),
      .o_head          (w_head[p]),
      .o_credit_return (o_credit_return[p])
    );
  end

  // Picks a queue when the line frees up
  tx_arbiter u_arbiter (
    .i_Clock     (i_Clock),
    .i_Rst_L     (i_Rst_L),
    .i_not_empty (w_not_empty),
    .i_head      (w_head),
    .i_tx_busy   (o_tx_active),
    .o_pop       (w_pop),
    .o_req_valid (w_req_valid),
    .o_req       (w_req)
  );

  // Busy doubles as the frame-active output
  uart_tx u_tx (
    .i_Clock        (i_Clock),
    .i_Rst_L        (i_Rst_L),
    .i_req_valid    (w_req_valid),
    .i_req          (w_req),
    .i_clks_per_bit (i_clks_per_bit),
    .o_tx_busy      (o_tx_active),
    .o_tx_serial    (o_tx_serial),
    .o_tx_src       (o_tx_src),
    .o_tx_done      (o_tx_done)
  );

endmodule

//--- uart_tx_hub_props.sv
// Concurrent checks bound onto the UART transmit hub top level
// Frame length check assumes clks_per_bit is steady over a frame
// Occupancy is rebuilt from writes and pops, with no view of queue internals
`include "uart_hub_defines.svh"

module uart_tx_hub_props
  import uart_hub_pkg::*;
(
  input logic                            i_Clock,
  input logic                            i_Rst_L,
  input logic [`UART_HUB_CPB_WIDTH-1:0]  i_clks_per_bit,
  input logic [`UART_HUB_NUM_PORTS-1:0]  i_wr_valid,
  input logic [`UART_HUB_NUM_PORTS-1:0]  i_credit_return,
  input logic [`UART_HUB_NUM_PORTS-1:0]  i_not_empty,
  input logic [`UART_HUB_NUM_PORTS-1:0]  i_pop,
  input logic                            i_tx_serial,
  input logic                            i_tx_active,
  input logic                            i_tx_done
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH     = `UART_HUB_FIFO_DEPTH;
  localparam int NUM_PORTS = `UART_HUB_NUM_PORTS;

  int        r_frame_cycles;
  int        r_occ [NUM_PORTS];
  port_idx_t r_last;
  logic      r_have_last;

  // Failed assertions so far
  int        fail_count = 0;

  ////////////////////////////////////////
  // Reference counters
  ////////////////////////////////////////

  always_ff @(posedge i_Clock or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_frame_cycles <= 0;
      r_last         <= '0;
      r_have_last    <= 1'b0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        r_occ[p] <= 0;
      end
    end
    else
    begin
      // Count busy cycles and clear on done
      if (i_tx_done)
      begin
        r_frame_cycles <= 0;
      end
      else if (i_tx_active)
      begin
        r_frame_cycles <= r_frame_cycles + 1;
      end
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        r_occ[p] <= r_occ[p] + int'(i_wr_valid[p]) - int'(i_pop[p]);
        // Last port granted
        if (i_pop[p])
        begin
          r_last      <= port_idx_t'(p);
          r_have_last <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Line and frame timing
  ////////////////////////////////////////

  a_line_idle: assert property (@(posedge i_Clock) disable iff (!i_Rst_L)
    !i_tx_active |-> i_tx_serial)
  else
  begin
    $error("serial line low outside a frame");
    fail_count++;
  end

  a_start_low: assert property (@(posedge i_Clock) disable iff (!i_Rst_L)
    $rose(i_tx_active) |-> !i_tx_serial)
  else
  begin
    $error("frame did not open with a low start bit");
    fail_count++;
  end

  a_done_end: assert property (@(posedge i_Clock) disable iff (!i_Rst_L)
    i_tx_done |-> !i_tx_active && $past(i_tx_active) && $past(i_tx_serial))
  else
  begin
    $error("done strobe not at the end of a stop bit");
    fail_count++;
  end

  a_frame_len: assert property (@(posedge i_Clock) disable iff (!i_Rst_L)
    i_tx_done |-> r_frame_cycles == 10 * int'(i_clks_per_bit))
  else
  begin
    $error("frame length is not ten bit periods");
    fail_count++;
  end

  // Waiting bytes go out with at most two idle cycles
  a_back_to_back: assert property (@(posedge i_Clock) disable iff (!i_Rst_L)
    i_tx_done && (|i_not_empty) |-> ##2 i_tx_active)
  else
  begin
    $error("gap between queued frames too long");
    fail_count++;
  end

  ////////////////////////////////////////
  // Arbitration and credits
  ////////////////////////////////////////

  a_pop_rules: assert property (@(posedge i_Clock) disable iff (!i_Rst_L)
    $onehot0(i_pop) && (!(|i_pop) || !i_tx_active))
  else
  begin
    $error("pop to more than one queue or while busy");
    fail_count++;
  end

  a_fair: assert property (@(posedge i_Clock) disable iff (!i_Rst_L)
    (&i_not_empty) && (|i_pop) && r_have_last |-> !i_pop[r_last])
  else
  begin
    $error("same port granted twice while both waited");
    fail_count++;
  end

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_port
    a_no_overflow: assert property (@(posedge i_Clock) disable iff (!i_Rst_L)
      i_wr_valid[p] |-> r_occ[p] < DEPTH)
    else
    begin
      $error("write into a full queue");
      fail_count++;
    end

    a_credit_pop: assert property (@(posedge i_Clock) disable iff (!i_Rst_L)
      i_credit_return[p] |-> $past(i_pop[p]))
    else
    begin
      $error("credit returned without a pop");
      fail_count++;
    end
  end

endmodule

//--- uart_tx_hub_tb.sv
// Testbench for the two-port UART transmit hub with clks_per_bit fixed at 4
// Producers write only against credit; bytes and gaps come from an LFSR
// Negedge decoder rebuilds each frame and checks it against per-port queues
// Timing and protocol rules are left to the bound property module
`include "uart_hub_defines.svh"

module uart_tx_hub_tb
  import uart_hub_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PORTS = `UART_HUB_NUM_PORTS;
  localparam int DEPTH     = `UART_HUB_FIFO_DEPTH;
  localparam int CPB       = 4;

  logic                            clock;
  logic                            rst_l;
  logic [`UART_HUB_CPB_WIDTH-1:0]  clks_per_bit;
  logic  [NUM_PORTS-1:0]           wr_valid;
  data_t [NUM_PORTS-1:0]           wr_data;
  logic  [NUM_PORTS-1:0]           credit_return;
  logic                            tx_serial;
  logic                            tx_active;
  port_idx_t                       tx_src;
  logic                            tx_done;

  // Producer side bookkeeping
  int          credits  [NUM_PORTS];
  int          to_send  [NUM_PORTS];
  int          gap      [NUM_PORTS];
  int          returned [NUM_PORTS];
  int          framed   [NUM_PORTS];
  data_t       exp_q    [NUM_PORTS][$];
  int          gap_bits;
  logic [31:0] lfsr;

  // Decoder and result counters
  logic  dec_on;
  int    dec_cnt;
  data_t dec_byte;
  logic  dec_stop;
  data_t exp_byte;
  int    errors;
  int    frames;
  int    tests;

  initial
  begin
    clock = 1'b0;
    forever
    begin
      #2 clock = ~clock;
    end
  end

  uart_tx_hub UUT (
    .i_Clock         (clock),
    .i_Rst_L         (rst_l),
    .i_clks_per_bit  (clks_per_bit),
    .i_wr_valid      (wr_valid),
    .i_wr_data       (wr_data),
    .o_credit_return (credit_return),
    .o_tx_serial     (tx_serial),
    .o_tx_active     (tx_active),
    .o_tx_src        (tx_src),
    .o_tx_done       (tx_done)
  );

  bind uart_tx_hub uart_tx_hub_props u_props (
    .i_Clock         (i_Clock),
    .i_Rst_L         (i_Rst_L),
    .i_clks_per_bit  (i_clks_per_bit),
    .i_wr_valid      (i_wr_valid),
    .i_credit_return (o_credit_return),
    .i_not_empty     (w_not_empty),
    .i_pop           (w_pop),
    .i_tx_serial     (o_tx_serial),
    .i_tx_active     (o_tx_active),
    .i_tx_done       (o_tx_done)
  );

  // 32-bit Fibonacci LFSR with taps 32 22 2 1, stepped once per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    logic       fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      v    = {v[6:0], lfsr[31]};
      lfsr = {lfsr[30:0], fb};
    end
    return v;
  endfunction

  // Compare a finished frame with the oldest byte of its port
  task automatic check_frame();
    port_idx_t src;
    src    = tx_src;
    dec_on = 1'b0;
    frames++;
    framed[src]++;
    if (exp_q[src].size() == 0)
    begin
      $display("Port %0d sent a frame it never wrote, at %0t", src, $time);
      errors++;
    end
    else
    begin
      exp_byte = exp_q[src].pop_front();
      assert (dec_byte == exp_byte && dec_stop)
      else
      begin
        $display("CHECK FAILED at %0t: port %0d got %02h stop %0b, expected %02h",
                 $time, src, dec_byte, dec_stop, exp_byte);
        errors++;
      end
    end
  endtask

  ////////////////////////////////////////
  // Decoder and producers run on the falling edge
  ////////////////////////////////////////

  always @(negedge clock)
  begin
    int k;
    if (rst_l)
    begin
      // Bit k sampled CPB/2 negedges into its period
      if (dec_on)
      begin
        dec_cnt = dec_cnt + 1;
        k       = dec_cnt / CPB;
        if (dec_cnt % CPB == CPB / 2)
        begin
          if (k == 0)
          begin
            assert (!tx_serial)
            else
            begin
              $display("CHECK FAILED at %0t: start bit high at mid-bit", $time);
              errors++;
            end
          end
          else if (k <= 8)
          begin
            dec_byte[k - 1] = tx_serial;
          end
          else if (k == 9)
          begin
            dec_stop = tx_serial;
          end
        end
      end
      else if (!tx_serial)
      begin
        dec_on   = 1'b1;
        dec_cnt  = 0;
        dec_stop = 1'b0;
      end
      if (tx_done)
      begin
        check_frame();
      end
      // At most one write per port per cycle and only against credit
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        wr_valid[p] = 1'b0;
        if (credit_return[p])
        begin
          credits[p]++;
          returned[p]++;
        end
        if (gap[p] > 0)
        begin
          gap[p]--;
        end
        else if (to_send[p] > 0 && credits[p] > 0)
        begin
          wr_data[p]  = rand_bits(8);
          wr_valid[p] = 1'b1;
          exp_q[p].push_back(wr_data[p]);
          credits[p]--;
          to_send[p]--;
          gap[p] = int'(rand_bits(gap_bits));
        end
      end
    end
  end

  // Line idle and nothing returned before the first write
  task automatic idle_check();
    for (int i = 0; i < 8; i++)
    begin
      @(negedge clock);
      assert (tx_serial && !tx_active && !tx_done && credit_return == '0)
      else
      begin
        $display("CHECK FAILED at %0t: hub not idle after reset", $time);
        errors++;
      end
    end
    tests++;
    $display("Test %0d reset idle finished, %0d errors so far", tests, errors);
  endtask

  // Send n0 and n1 bytes, wait for every frame, then compare credits
  task automatic run_traffic(input string name, input int n0, input int n1,
                             input int gbits);
    int cycles;
    int limit;
    limit = (n0 + n1) * (12 * CPB + 8) + 200;
    @(posedge clock);
    gap_bits   = gbits;
    to_send[0] = n0;
    to_send[1] = n1;
    cycles     = 0;
    while (to_send[0] + to_send[1] + exp_q[0].size() + exp_q[1].size() != 0)
    begin
      @(posedge clock);
      cycles++;
      if (cycles > limit)
      begin
        $display("Timeout in test %s: traffic did not drain in %0d cycles", name, limit);
        $display("TB FAILED");
        $finish;
      end
    end
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      assert (credits[p] == DEPTH && returned[p] == framed[p])
      else
      begin
        $display("CHECK FAILED at %0t: port %0d credits %0d, returned %0d, framed %0d",
                 $time, p, credits[p], returned[p], framed[p]);
        errors++;
      end
    end
    tests++;
    $display("Test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    rst_l        = 1'b0;
    clks_per_bit = CPB;
    wr_valid     = '0;
    wr_data      = '0;
    lfsr         = 32'd69120;
    gap_bits     = 0;
    dec_on       = 1'b0;
    dec_cnt      = 0;
    dec_byte     = '0;
    dec_stop     = 1'b0;
    errors       = 0;
    frames       = 0;
    tests        = 0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      credits[p]  = DEPTH;
      to_send[p]  = 0;
      gap[p]      = 0;
      returned[p] = 0;
      framed[p]   = 0;
    end
    repeat (16) @(negedge clock);
    rst_l = 1'b1;

    idle_check();
    run_traffic("single byte port 0", 1, 0, 0);
    run_traffic("single byte port 1", 0, 1, 0);
    run_traffic("both saturated", 12, 12, 0);
    run_traffic("back-pressure port 1", 0, 10, 0);
    run_traffic("random gaps", 24, 24, 2);

    errors = errors + UUT.u_props.fail_count;
    $display("%0d tests, %0d frames, %0d errors", tests, frames, errors);
    if (errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
uart_hub_pkg.sv
credit_fifo.sv
tx_arbiter.sv
uart_tx.sv
uart_tx_hub.sv
uart_tx_hub_props.sv
uart_tx_hub_tb.sv

//--- Bender.yml
package:
  name: uart_tx_hub

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uart_hub_pkg.sv
      - credit_fifo.sv
      - tx_arbiter.sv
      - uart_tx.sv
      - uart_tx_hub.sv
  - target: test
    include_dirs:
      - .
    files:
      - uart_tx_hub_props.sv
      - uart_tx_hub_tb.sv
